//--- dv/raster_cmd_tests.txt
// kind (opcode)  header word  payload base  back-pressure flag
// payload word i is base plus i
00000001 10000008 00001000 00000000
00000001 10000014 00002000 00000001
00000002 20000003 abcd0010 00000000
00000002 20000000 00000000 00000000
00000002 20000004 12340100 00000001
00000003 30000001 cafe0001 00000000
00000003 30000006 dead5678 00000000
00000003 30000000 01234567 00000000
00000005 50000000 00003000 00000000
00000005 50000000 00004000 00000001
00000004 40000005 00000000 00000000
00000004 4000000a 00000000 00000000
00000004 4000000f 00000000 00000000
00000000 00000000 00000000 00000000
00000001 10000005 00005000 00000001

//--- verilog.f
rtl/raster_cmd_pkg.sv
rtl/lut_stream_if.sv
rtl/cmd_parser.sv
rtl/fog_lut_store.sv
rtl/raster_cmd_top.sv
dv/raster_cmd_tb.sv

//--- dv/raster_cmd_tb.sv
`timescale 1ns/10ps
`default_nettype none

module raster_cmd_tb import raster_cmd_pkg::*;;

    localparam int MAX_TESTS = 32;

    logic          aclk;
    logic          resetn;
    logic          cmd_tvalid;
    logic          cmd_tready;
    logic [31:0]   cmd_tdata;
    logic          raster_tvalid;
    logic          raster_tready;
    logic          raster_tlast;
    logic [31:0]   raster_tdata;
    logic          raster_running;
    logic          pixel_in_pipeline;
    logic          start_rendering;
    logic          tex_tvalid;
    logic          tex_tready;
    logic          tex_tlast;
    logic [15:0]   tex_tdata;
    logic          color_apply;
    logic          color_applied;
    logic          color_commit;
    logic          color_memset;
    logic          depth_apply;
    logic          depth_applied;
    logic          depth_commit;
    logic          depth_memset;
    logic [31:0]   cfg_fragment_pipeline;
    logic [31:0]   cfg_fog_color;
    logic [31:0]   cfg_tex_env;
    logic [31:0]   cfg_texture_config;
    logic [31:0]   cfg_tex_env_color;
    logic [31:0]   cfg_clear_color;
    logic [15:0]   cfg_clear_depth;
    parser_state_e parser_state;
    logic [5:0]    fog_addr;
    logic [31:0]   fog_data;

    logic [31:0]   tests_mem [4*MAX_TESTS];
    logic [31:0]   exp_cfg [CFG_REG_COUNT];
    logic [31:0]   raster_q [$];
    logic          raster_last_q [$];
    logic [15:0]   tex_q [$];
    logic          tex_last_q [$];
    logic          back_pressure;
    logic          in_fb;
    logic          start_seen;
    logic          color_apply_seen;
    logic          depth_apply_seen;
    integer        seed;
    int            errors;
    int            num_tests;
    int            cycles;
    int            cycle_limit;

    raster_cmd_top #(
        .TEXTURE_WIDTH (16)
    ) u_dut (
        .aclk                  (aclk),
        .resetn                (resetn),
        .cmd_tvalid            (cmd_tvalid),
        .cmd_tready            (cmd_tready),
        .cmd_tdata             (cmd_tdata),
        .raster_tvalid         (raster_tvalid),
        .raster_tready         (raster_tready),
        .raster_tlast          (raster_tlast),
        .raster_tdata          (raster_tdata),
        .raster_running        (raster_running),
        .pixel_in_pipeline     (pixel_in_pipeline),
        .start_rendering       (start_rendering),
        .tex_tvalid            (tex_tvalid),
        .tex_tready            (tex_tready),
        .tex_tlast             (tex_tlast),
        .tex_tdata             (tex_tdata),
        .color_apply           (color_apply),
        .color_applied         (color_applied),
        .color_commit          (color_commit),
        .color_memset          (color_memset),
        .depth_apply           (depth_apply),
        .depth_applied         (depth_applied),
        .depth_commit          (depth_commit),
        .depth_memset          (depth_memset),
        .cfg_fragment_pipeline (cfg_fragment_pipeline),
        .cfg_fog_color         (cfg_fog_color),
        .cfg_tex_env           (cfg_tex_env),
        .cfg_texture_config    (cfg_texture_config),
        .cfg_tex_env_color     (cfg_tex_env_color),
        .cfg_clear_color       (cfg_clear_color),
        .cfg_clear_depth       (cfg_clear_depth),
        .parser_state          (parser_state),
        .fog_addr              (fog_addr),
        .fog_data              (fog_data)
    );

    always
        #10 aclk = ~aclk;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        begin
            assert (got === exp)
            else
            begin
                $display("FAIL %s expected %h got %h", name, exp, got);
                errors++;
            end
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        begin
            assert (got == exp)
            else
            begin
                $display("wrong number of beats on %s: expected %0d, got %0d", name, exp, got);
                errors++;
            end
        end
    endtask

    // Payload length implied by the header rules
    function automatic int payload_beats(input logic [31:0] kind, input logic [31:0] header);
        case (kind[3:0])
            OP_TRIANGLE_STREAM: return int'(header[13:0]);
            OP_TEXTURE_STREAM:  return (header[3:0] == 4'd0) ? 0 : (1 << header[3:0]);
            OP_RENDER_CONFIG:   return 1;
            OP_FOG_LUT_STREAM:  return FOG_LUT_DEPTH;
            default:            return 0;
        endcase
    endfunction

    task automatic send_word(input logic [31:0] word);
        begin
            cmd_tvalid = 1'b1;
            cmd_tdata  = word;
            @(posedge aclk);
            while (!cmd_tready)
                @(posedge aclk);
            #1 cmd_tvalid = 1'b0;
        end
    endtask

    task automatic wait_for_header_state();
        begin
            @(posedge aclk);
            while (parser_state != PS_HEADER)
                @(posedge aclk);
            #1;
        end
    endtask

    // Everything idle straight out of reset
    task automatic check_reset_values();
        begin
            check_value("parser_state", PS_WAIT_IDLE, parser_state);
            check_value("cmd_tready", 1'b0, cmd_tready);
            check_value("raster_tvalid", 1'b0, raster_tvalid);
            check_value("tex_tvalid", 1'b0, tex_tvalid);
            check_value("start_rendering", 1'b0, start_rendering);
            check_value("color_apply", 1'b0, color_apply);
            check_value("depth_apply", 1'b0, depth_apply);
            check_value("cfg_clear_color", 32'h0, cfg_clear_color);
        end
    endtask

    task automatic check_config();
        begin
            check_value("cfg_fragment_pipeline", exp_cfg[0], cfg_fragment_pipeline);
            check_value("cfg_fog_color", exp_cfg[1], cfg_fog_color);
            check_value("cfg_tex_env", exp_cfg[2], cfg_tex_env);
            check_value("cfg_texture_config", exp_cfg[3], cfg_texture_config);
            check_value("cfg_tex_env_color", exp_cfg[4], cfg_tex_env_color);
            check_value("cfg_clear_color", exp_cfg[5], cfg_clear_color);
            check_value("cfg_clear_depth", {16'h0, exp_cfg[6][15:0]}, {16'h0, cfg_clear_depth});
        end
    endtask

    task automatic sweep_fog_table(input logic [31:0] base);
        begin
            for (int a = 0; a < FOG_LUT_DEPTH; a++)
            begin
                @(posedge aclk);
                #1 fog_addr = a[5:0];
                @(negedge aclk);
                check_value("fog_data", base + a, fog_data);
            end
            // Past the table end
            @(posedge aclk);
            #1 fog_addr = 6'd40;
            @(negedge aclk);
            check_value("fog_data", 32'h0, fog_data);
            @(posedge aclk);
            #1 fog_addr = 6'd0;
        end
    endtask

    task automatic run_test(input int t, output logic ok);
        logic [31:0] kind;
        logic [31:0] header;
        logic [31:0] base;
        int          beats;
        int          errs_before;
        begin
            kind        = tests_mem[4*t];
            header      = tests_mem[4*t+1];
            base        = tests_mem[4*t+2];
            beats       = payload_beats(kind, header);
            errs_before = errors;
            raster_q.delete();
            raster_last_q.delete();
            tex_q.delete();
            tex_last_q.delete();
            start_seen       = 1'b0;
            color_apply_seen = 1'b0;
            depth_apply_seen = 1'b0;
            back_pressure    = tests_mem[4*t+3][0];
            in_fb            = (kind[3:0] == OP_FRAMEBUFFER);

            send_word(header);
            for (int i = 0; i < beats; i++)
                send_word(base + i);
            wait_for_header_state();
            in_fb         = 1'b0;
            back_pressure = 1'b0;

            if (kind[3:0] == OP_TRIANGLE_STREAM)
            begin
                check_count("raster stream", beats, raster_q.size());
                for (int i = 0; i < beats && i < raster_q.size(); i++)
                begin
                    check_value("raster_tdata", base + i, raster_q[i]);
                    check_value("raster_tlast", (i == beats - 1), raster_last_q[i]);
                end
                assert (start_seen)
                else
                begin
                    $display("start_rendering never rose before the next command");
                    errors++;
                end
            end
            else
                check_count("raster stream", 0, raster_q.size());

            if (kind[3:0] == OP_TEXTURE_STREAM)
            begin
                check_count("texture stream", beats, tex_q.size());
                for (int i = 0; i < beats && i < tex_q.size(); i++)
                begin
                    check_value("tex_tdata", {16'h0, base[15:0] + 16'(i)}, {16'h0, tex_q[i]});
                    check_value("tex_tlast", (i == beats - 1), tex_last_q[i]);
                end
            end
            else
                check_count("texture stream", 0, tex_q.size());

            case (kind[3:0])
                OP_RENDER_CONFIG:
                begin
                    exp_cfg[header[2:0]] = base;
                    check_config();
                end
                OP_FOG_LUT_STREAM:
                    sweep_fog_table(base);
                OP_FRAMEBUFFER:
                begin
                    check_value("color_apply", header[FB_COLOR_SELECT], color_apply_seen);
                    check_value("depth_apply", header[FB_DEPTH_SELECT], depth_apply_seen);
                    check_value("color_commit", header[FB_COMMIT], color_commit);
                    check_value("color_memset", header[FB_MEMSET], color_memset);
                    check_value("depth_commit", header[FB_COMMIT], depth_commit);
                    check_value("depth_memset", header[FB_MEMSET], depth_memset);
                end
                default:
                    ;
            endcase
            ok = (errors == errs_before);
            $display("test %0d kind %0h header %h: %0d errors", t, kind, header,
                     errors - errs_before);
        end
    endtask

    // Downstream ready, random under back-pressure
    initial
    begin
        integer r;
        raster_tready = 1'b1;
        tex_tready    = 1'b1;
        forever
        begin
            @(posedge aclk);
            r = $random(seed);
            #1;
            raster_tready = back_pressure ? r[0] : 1'b1;
            tex_tready    = back_pressure ? r[1] : 1'b1;
        end
    end

    // Rasterizer model
    initial
    begin
        raster_running    = 1'b0;
        pixel_in_pipeline = 1'b0;
        forever
        begin
            @(posedge aclk);
            if (start_rendering === 1'b1)
            begin
                @(posedge aclk);
                #1 raster_running = 1'b1;
                repeat (4) @(posedge aclk);
                #1 raster_running = 1'b0;
            end
        end
    end

    // Color and depth buffer models
    initial
    begin
        color_applied = 1'b1;
        forever
        begin
            @(posedge aclk);
            if (color_apply === 1'b1)
            begin
                #1 color_applied = 1'b0;
                repeat (3) @(posedge aclk);
                #1 color_applied = 1'b1;
            end
        end
    end

    initial
    begin
        depth_applied = 1'b1;
        forever
        begin
            @(posedge aclk);
            if (depth_apply === 1'b1)
            begin
                #1 depth_applied = 1'b0;
                repeat (3) @(posedge aclk);
                #1 depth_applied = 1'b1;
            end
        end
    end

    // Output stream monitors
    always @(posedge aclk)
    begin
        if (resetn === 1'b1)
        begin
            if (raster_tvalid && raster_tready)
            begin
                raster_q.push_back(raster_tdata);
                raster_last_q.push_back(raster_tlast);
            end
            if (tex_tvalid && tex_tready)
            begin
                tex_q.push_back(tex_tdata);
                tex_last_q.push_back(tex_tlast);
            end
            if (start_rendering)
                start_seen = 1'b1;
            if (color_apply)
                color_apply_seen = 1'b1;
            if (depth_apply)
                depth_apply_seen = 1'b1;
            if (in_fb && !(color_applied && depth_applied))
            begin
                assert (!cmd_tready)
                else
                begin
                    $display("cmd_tready went high before the buffers finished applying");
                    errors++;
                end
            end
        end
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        int   beat_sum;
        int   passed;
        int   failed;
        logic ok;
        aclk          = 1'b0;
        resetn        = 1'b0;
        cmd_tvalid    = 1'b0;
        cmd_tdata     = '0;
        fog_addr      = '0;
        back_pressure = 1'b0;
        in_fb         = 1'b0;
        seed          = 90;
        errors        = 0;
        cycles        = 0;
        cycle_limit   = 0;
        beat_sum      = 0;
        passed        = 0;
        failed        = 0;
        for (int k = 0; k < CFG_REG_COUNT; k++)
            exp_cfg[k] = '0;
        for (int k = 0; k < 4*MAX_TESTS; k++)
            tests_mem[k] = ~32'(k);
        $readmemh("dv/raster_cmd_tests.txt", tests_mem);

        // Only loaded lines have a kind below 16
        num_tests = 0;
        while (num_tests < MAX_TESTS && tests_mem[4*num_tests][31:4] == 28'h0)
        begin
            beat_sum += payload_beats(tests_mem[4*num_tests], tests_mem[4*num_tests+1]);
            num_tests++;
        end
        cycle_limit = 200 * num_tests + 4 * beat_sum;

        repeat (2) @(posedge aclk);
        #1 resetn = 1'b1;
        check_reset_values();
        $display("reset values: %0d errors", errors);

        for (int t = 0; t < num_tests; t++)
        begin
            run_test(t, ok);
            if (ok)
                passed++;
            else
                failed++;
        end

        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (errors == 0 && num_tests > 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/raster_cmd_top.sv
`timescale 1ns/10ps
`default_nettype none

module raster_cmd_top import raster_cmd_pkg::*; #(
    parameter int TEXTURE_WIDTH = 16
) (
    input  wire                         aclk,
    input  wire                         resetn,

    input  wire                         cmd_tvalid,
    output logic                        cmd_tready,
    input  wire  [CMD_WIDTH-1:0]        cmd_tdata,

    output logic                        raster_tvalid,
    input  wire                         raster_tready,
    output logic                        raster_tlast,
    output logic [CMD_WIDTH-1:0]        raster_tdata,
    input  wire                         raster_running,
    input  wire                         pixel_in_pipeline,
    output logic                        start_rendering,

    output logic                        tex_tvalid,
    input  wire                         tex_tready,
    output logic                        tex_tlast,
    output logic [TEXTURE_WIDTH-1:0]    tex_tdata,

    output logic                        color_apply,
    input  wire                         color_applied,
    output logic                        color_commit,
    output logic                        color_memset,

    output logic                        depth_apply,
    input  wire                         depth_applied,
    output logic                        depth_commit,
    output logic                        depth_memset,

    output logic [31:0]                 cfg_fragment_pipeline,
    output logic [31:0]                 cfg_fog_color,
    output logic [31:0]                 cfg_tex_env,
    output logic [31:0]                 cfg_texture_config,
    output logic [31:0]                 cfg_tex_env_color,
    output logic [31:0]                 cfg_clear_color,
    output logic [15:0]                 cfg_clear_depth,

    output parser_state_e               parser_state,

    // Fog lookup for the fragment pipeline
    input  wire  [5:0]                  fog_addr,
    output logic [31:0]                 fog_data
);

    lut_stream_if fog_stream ();

    cmd_parser #(
        .TEXTURE_WIDTH (TEXTURE_WIDTH)
    ) u_parser (
        .aclk                  (aclk),
        .resetn                (resetn),
        .cmd_tvalid            (cmd_tvalid),
        .cmd_tready            (cmd_tready),
        .cmd_tdata             (cmd_tdata),
        .fog                   (fog_stream.source),
        .raster_tvalid         (raster_tvalid),
        .raster_tready         (raster_tready),
        .raster_tlast          (raster_tlast),
        .raster_tdata          (raster_tdata),
        .raster_running        (raster_running),
        .pixel_in_pipeline     (pixel_in_pipeline),
        .start_rendering       (start_rendering),
        .tex_tvalid            (tex_tvalid),
        .tex_tready            (tex_tready),
        .tex_tlast             (tex_tlast),
        .tex_tdata             (tex_tdata),
        .color_apply           (color_apply),
        .color_applied         (color_applied),
        .color_commit          (color_commit),
        .color_memset          (color_memset),
        .depth_apply           (depth_apply),
        .depth_applied         (depth_applied),
        .depth_commit          (depth_commit),
        .depth_memset          (depth_memset),
        .cfg_fragment_pipeline (cfg_fragment_pipeline),
        .cfg_fog_color         (cfg_fog_color),
        .cfg_tex_env           (cfg_tex_env),
        .cfg_texture_config    (cfg_texture_config),
        .cfg_tex_env_color     (cfg_tex_env_color),
        .cfg_clear_color       (cfg_clear_color),
        .cfg_clear_depth       (cfg_clear_depth),
        .parser_state          (parser_state)
    );

    fog_lut_store u_fog_lut (
        .aclk     (aclk),
        .resetn   (resetn),
        .fog      (fog_stream.sink),
        .fog_addr (fog_addr),
        .fog_data (fog_data)
    );

endmodule

`default_nettype wire

//--- rtl/fog_lut_store.sv
`timescale 1ns/10ps
`default_nettype none

module fog_lut_store import raster_cmd_pkg::*; (
    input  wire         aclk,
    input  wire         resetn,

    lut_stream_if.sink  fog,

    input  wire  [5:0]  fog_addr,
    output logic [31:0] fog_data
);

    logic [31:0] lut [FOG_LUT_DEPTH];
    logic [5:0]  wr_addr;
    logic        wr_beat;

    // The table never stalls the stream
    assign fog.ready = 1'b1;
    assign wr_beat   = fog.valid && fog.ready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wr_addr <= '0;
        end
        else if (wr_beat)
        begin
            // Next table load starts over at entry 0
            if (fog.last)
                wr_addr <= '0;
            else
                wr_addr <= wr_addr + 6'd1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (wr_beat && int'(wr_addr) < FOG_LUT_DEPTH)
            lut[wr_addr] <= fog.data;
    end

    // Combinational lookup for the fragment pipeline
    always_comb
    begin
        if (int'(fog_addr) < FOG_LUT_DEPTH)
            fog_data = lut[fog_addr];
        else
            fog_data = '0;
    end

endmodule

`default_nettype wire

//--- rtl/cmd_parser.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_parser import raster_cmd_pkg::*; #(
    parameter int TEXTURE_WIDTH = 16
) (
    input  wire                         aclk,
    input  wire                         resetn,

    input  wire                         cmd_tvalid,
    output logic                        cmd_tready,
    input  wire  [CMD_WIDTH-1:0]        cmd_tdata,

    lut_stream_if.source                fog,

    output logic                        raster_tvalid,
    input  wire                         raster_tready,
    output logic                        raster_tlast,
    output logic [CMD_WIDTH-1:0]        raster_tdata,
    input  wire                         raster_running,
    input  wire                         pixel_in_pipeline,
    output logic                        start_rendering,

    output logic                        tex_tvalid,
    input  wire                         tex_tready,
    output logic                        tex_tlast,
    output logic [TEXTURE_WIDTH-1:0]    tex_tdata,

    output logic                        color_apply,
    input  wire                         color_applied,
    output logic                        color_commit,
    output logic                        color_memset,

    output logic                        depth_apply,
    input  wire                         depth_applied,
    output logic                        depth_commit,
    output logic                        depth_memset,

    output logic [31:0]                 cfg_fragment_pipeline,
    output logic [31:0]                 cfg_fog_color,
    output logic [31:0]                 cfg_tex_env,
    output logic [31:0]                 cfg_texture_config,
    output logic [31:0]                 cfg_tex_env_color,
    output logic [31:0]                 cfg_clear_color,
    output logic [15:0]                 cfg_clear_depth,

    output parser_state_e               parser_state
);

    typedef enum logic {
        AT_IDLE,
        AT_WAIT_END
    } apply_state_e;

    cmd_op_e                    hdr_op;
    logic [TRI_BEATS_WIDTH-1:0] tri_beats;
    logic [TEX_SIZE_WIDTH-1:0]  tex_size;
    logic [15:0]                beat_count;
    cfg_reg_e                   cfg_index;
    logic [31:0]                cfg_regs [CFG_REG_COUNT];
    logic                       payload_accept;
    logic                       last_beat;
    logic                       raster_load;
    logic                       tex_load;
    logic                       fog_load;
    logic                       fb_header;
    logic                       idle_ok;
    logic                       both_applied;
    logic                       apply_pending;
    apply_state_e               apply_state;

    assign hdr_op    = cmd_op_e'(cmd_tdata[OP_LSB +: OP_WIDTH]);
    assign tri_beats = cmd_tdata[TRI_BEATS_LSB +: TRI_BEATS_WIDTH];
    assign tex_size  = cmd_tdata[TEX_SIZE_LSB +: TEX_SIZE_WIDTH];

    assign payload_accept = cmd_tvalid && cmd_tready;
    assign last_beat      = (beat_count == 16'd1);
    assign raster_load    = payload_accept && (parser_state == PS_TRIANGLE);
    assign tex_load       = payload_accept && (parser_state == PS_TEXTURE);
    assign fog_load       = payload_accept && (parser_state == PS_FOG);
    assign fb_header      = cmd_tvalid && (parser_state == PS_HEADER)
                            && (hdr_op == OP_FRAMEBUFFER);
    assign both_applied   = color_applied && depth_applied;

    // Downstream quiet and all output registers drained
    assign idle_ok = raster_tready && !raster_running && !pixel_in_pipeline
                     && !apply_pending && both_applied && !start_rendering
                     && !raster_tvalid && !tex_tvalid && !fog.valid;

    // A payload beat is taken when the target register can move on
    always_comb
    begin
        case (parser_state)
            PS_HEADER:   cmd_tready = 1'b1;
            PS_CONFIG:   cmd_tready = 1'b1;
            PS_TRIANGLE: cmd_tready = !raster_tvalid || raster_tready;
            PS_TEXTURE:  cmd_tready = !tex_tvalid || tex_tready;
            PS_FOG:      cmd_tready = !fog.valid || fog.ready;
            default:     cmd_tready = 1'b0;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            parser_state <= PS_WAIT_IDLE;
            beat_count   <= '0;
            cfg_index    <= CFG_FRAGMENT_PIPELINE;
        end
        else
        begin
            case (parser_state)
                PS_WAIT_IDLE:
                begin
                    if (idle_ok)
                        parser_state <= PS_HEADER;
                end
                PS_HEADER:
                begin
                    if (cmd_tvalid)
                    begin
                        case (hdr_op)
                            OP_TRIANGLE_STREAM:
                            begin
                                beat_count   <= {2'b00, tri_beats};
                                parser_state <= (tri_beats != '0) ? PS_TRIANGLE : PS_WAIT_IDLE;
                            end
                            OP_TEXTURE_STREAM:
                            begin
                                // Size 0 carries no payload at all
                                beat_count   <= 16'd1 << tex_size;
                                parser_state <= (tex_size != '0) ? PS_TEXTURE : PS_WAIT_IDLE;
                            end
                            OP_RENDER_CONFIG:
                            begin
                                cfg_index    <= cfg_reg_e'(cmd_tdata[CFG_INDEX_LSB +: CFG_INDEX_WIDTH]);
                                parser_state <= PS_CONFIG;
                            end
                            OP_FOG_LUT_STREAM:
                            begin
                                beat_count   <= 16'(FOG_LUT_DEPTH);
                                parser_state <= PS_FOG;
                            end
                            default:
                                parser_state <= PS_WAIT_IDLE;
                        endcase
                    end
                end
                PS_TRIANGLE, PS_TEXTURE, PS_FOG:
                begin
                    if (payload_accept)
                    begin
                        beat_count <= beat_count - 16'd1;
                        if (last_beat)
                            parser_state <= PS_WAIT_IDLE;
                    end
                end
                PS_CONFIG:
                begin
                    if (cmd_tvalid)
                        parser_state <= PS_WAIT_IDLE;
                end
                default:
                    parser_state <= PS_WAIT_IDLE;
            endcase
        end
    end

    // Rasterizer output register
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            raster_tvalid <= 1'b0;
            raster_tlast  <= 1'b0;
        end
        else if (raster_load)
        begin
            raster_tvalid <= 1'b1;
            raster_tlast  <= last_beat;
            raster_tdata  <= cmd_tdata;
        end
        else if (raster_tready)
        begin
            raster_tvalid <= 1'b0;
            raster_tlast  <= 1'b0;
        end
    end

    // Texture output register, low bits of each word
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            tex_tvalid <= 1'b0;
            tex_tlast  <= 1'b0;
        end
        else if (tex_load)
        begin
            tex_tvalid <= 1'b1;
            tex_tlast  <= last_beat;
            tex_tdata  <= cmd_tdata[TEXTURE_WIDTH-1:0];
        end
        else if (tex_tready)
        begin
            tex_tvalid <= 1'b0;
            tex_tlast  <= 1'b0;
        end
    end

    // Fog table output register
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            fog.valid <= 1'b0;
            fog.last  <= 1'b0;
        end
        else if (fog_load)
        begin
            fog.valid <= 1'b1;
            fog.last  <= last_beat;
            fog.data  <= cmd_tdata;
        end
        else if (fog.ready)
        begin
            fog.valid <= 1'b0;
            fog.last  <= 1'b0;
        end
    end

    // Held until the rasterizer reports it has started
    always_ff @(posedge aclk)
    begin
        if (!resetn)
            start_rendering <= 1'b0;
        else if (raster_load && last_beat)
            start_rendering <= 1'b1;
        else if (raster_running)
            start_rendering <= 1'b0;
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < CFG_REG_COUNT; i++)
                cfg_regs[i] <= '0;
        end
        else if (parser_state == PS_CONFIG && cmd_tvalid && int'(cfg_index) < CFG_REG_COUNT)
        begin
            cfg_regs[cfg_index] <= cmd_tdata;
        end
    end

    assign cfg_fragment_pipeline = cfg_regs[CFG_FRAGMENT_PIPELINE];
    assign cfg_fog_color         = cfg_regs[CFG_FOG_COLOR];
    assign cfg_tex_env           = cfg_regs[CFG_TEX_ENV];
    assign cfg_texture_config    = cfg_regs[CFG_TEXTURE_CONFIG];
    assign cfg_tex_env_color     = cfg_regs[CFG_TEX_ENV_COLOR];
    assign cfg_clear_color       = cfg_regs[CFG_CLEAR_COLOR];
    assign cfg_clear_depth       = cfg_regs[CFG_CLEAR_DEPTH][15:0];

    // Buffer apply handshake
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            color_apply   <= 1'b0;
            color_commit  <= 1'b0;
            color_memset  <= 1'b0;
            depth_apply   <= 1'b0;
            depth_commit  <= 1'b0;
            depth_memset  <= 1'b0;
            apply_pending <= 1'b0;
            apply_state   <= AT_IDLE;
        end
        else if (fb_header)
        begin
            color_commit  <= cmd_tdata[FB_COMMIT];
            color_memset  <= cmd_tdata[FB_MEMSET];
            depth_commit  <= cmd_tdata[FB_COMMIT];
            depth_memset  <= cmd_tdata[FB_MEMSET];
            color_apply   <= cmd_tdata[FB_COLOR_SELECT];
            depth_apply   <= cmd_tdata[FB_DEPTH_SELECT];
            // Nothing selected means nothing to wait for
            apply_pending <= cmd_tdata[FB_COLOR_SELECT] | cmd_tdata[FB_DEPTH_SELECT];
        end
        else
        begin
            if (!color_applied)
                color_apply <= 1'b0;
            if (!depth_applied)
                depth_apply <= 1'b0;
            case (apply_state)
                AT_IDLE:
                begin
                    if (apply_pending && !both_applied)
                        apply_state <= AT_WAIT_END;
                end
                AT_WAIT_END:
                begin
                    if (both_applied)
                    begin
                        apply_pending <= 1'b0;
                        apply_state   <= AT_IDLE;
                    end
                end
                default:
                    apply_state <= AT_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/lut_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

// Fog table entry stream, one table entry per beat
interface lut_stream_if;

    logic        valid;
    logic        ready;
    logic        last;
    logic [31:0] data;

    modport source (
        output valid,
        output last,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  last,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

//--- rtl/raster_cmd_pkg.sv
`default_nettype none

package raster_cmd_pkg;

    // Header opcodes in bits 31:28
    typedef enum logic [3:0] {
        OP_NOP             = 4'd0,
        OP_TRIANGLE_STREAM = 4'd1,
        OP_TEXTURE_STREAM  = 4'd2,
        OP_RENDER_CONFIG   = 4'd3,
        OP_FRAMEBUFFER     = 4'd4,
        OP_FOG_LUT_STREAM  = 4'd5
    } cmd_op_e;

    // Render config register file indices
    typedef enum logic [2:0] {
        CFG_FRAGMENT_PIPELINE = 3'd0,
        CFG_FOG_COLOR         = 3'd1,
        CFG_TEX_ENV           = 3'd2,
        CFG_TEXTURE_CONFIG    = 3'd3,
        CFG_TEX_ENV_COLOR     = 3'd4,
        CFG_CLEAR_COLOR       = 3'd5,
        CFG_CLEAR_DEPTH       = 3'd6
    } cfg_reg_e;

    typedef enum logic [2:0] {
        PS_WAIT_IDLE,
        PS_HEADER,
        PS_TRIANGLE,
        PS_TEXTURE,
        PS_CONFIG,
        PS_FOG,
        PS_FRAMEBUFFER
    } parser_state_e;

    localparam int CFG_REG_COUNT = 7;
    localparam int CMD_WIDTH     = 32;
    localparam int FOG_LUT_DEPTH = 33;

    // Header field positions
    localparam int OP_LSB          = 28;
    localparam int OP_WIDTH        = 4;
    localparam int TRI_BEATS_LSB   = 0;
    localparam int TRI_BEATS_WIDTH = 14;
    localparam int TEX_SIZE_LSB    = 0;
    localparam int TEX_SIZE_WIDTH  = 4;
    localparam int CFG_INDEX_LSB   = 0;
    localparam int CFG_INDEX_WIDTH = 3;

    // Framebuffer command bits
    localparam int FB_COMMIT       = 0;
    localparam int FB_MEMSET       = 1;
    localparam int FB_COLOR_SELECT = 2;
    localparam int FB_DEPTH_SELECT = 3;

endpackage

`default_nettype wire
